//--- files.f
source/core_isa_pkg.sv
source/trace_pkg.sv
source/trace_stage_track.sv
source/trace_record_store.sv
source/instr_trace_unit.sv
+incdir+tb
tb/tb_instr_trace_unit.sv

//--- Bender.yml
package:
  name: instr_trace_unit

sources:
  - source/core_isa_pkg.sv
  - source/trace_pkg.sv
  - source/trace_stage_track.sv
  - source/trace_record_store.sv
  - source/instr_trace_unit.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_instr_trace_unit.sv

//--- tb/trace_tests.svh
// Core stand-in driver tasks and directed trace tests included inside the testbench module
`ifndef TRACE_TESTS_SVH
`define TRACE_TESTS_SVH

  // Next cycle with every strobe idle while debug_mode and reset hold their value
  task automatic step();
    @(posedge clk_i);
    {id_valid, is_decoding, is_illegal, trigger_match, ebrk_insn} <= '0;
    {ebrk_force_debug_mode, ex_valid, data_misaligned, wb_bypass, ex_reg_we} <= '0;
    {ex_data_req, ex_data_gnt, ex_data_we, wb_valid, wb_reg_we} <= '0;
  endtask

  function automatic trace_rec_t base_rec(input logic [31:0] p, input logic [31:0] ins);
    trace_rec_t r;
    r         = '0;
    r.pc      = p;
    r.instr   = ins;
    r.rd_addr = ins[rd_msb:rd_lsb];
    return r;
  endfunction

  task automatic drive_decode(input trace_rec_t r);
    id_valid    <= !r.ebreak;
    is_decoding <= 1'b1;
    ebrk_insn   <= r.ebreak;
    ebrk_force_debug_mode <= r.ebreak;
    pc          <= r.pc;
    instr       <= r.instr;
    compressed  <= r.compressed;
  endtask

  // Called right after an edge, so the issue cycle is one past the mirror count
  task automatic issue(input trace_rec_t r);
    r.cycle = cyc + 1'b1;
    drive_decode(r);
    exp_q.push_back(r);
  endtask

  task automatic wb_write(input logic [4:0] a, input logic [31:0] d);
    wb_reg_we    <= 1'b1;
    wb_reg_addr  <= a;
    wb_reg_wdata <= d;
  endtask

  task automatic grant(input logic we, input logic [31:0] a, input logic [31:0] d);
    {ex_data_req, ex_data_gnt, ex_data_we} <= {2'b11, we};
    ex_data_addr  <= a;
    ex_data_wdata <= d;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) step();
    repeat (3) step();
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_base) begin
      pass_cnt++;
      $display("Test %s ok", name);
    end else begin
      fail_cnt++;
      $display("Test %s had %0d failed checks", name, err_cnt - test_base);
    end
    test_base = err_cnt;
  endtask

  task automatic run_all_tests();
    trace_rec_t r, r2;
    logic [4:0] rd;
    logic [31:0] a1;
    // In-order retire with random gaps
    for (int i = 0; i < 6; i++) begin
      rd = 5'(rnd(5));
      r = base_rec({30'(rnd(30)), 2'b00}, {12'(rnd(12)), 5'd1, 3'b000, rd, opc_op_imm});
      r.rd_we = 1'b1;
      r.rd_wdata = rnd(32);
      r.compressed = i[0];
      step();
      issue(r);
      step();
      ex_valid <= 1'b1;
      step();
      wb_valid <= 1'b1;
      wb_write(rd, r.rd_wdata);
      repeat (rnd(2)) step();
    end
    drain();
    end_test("in_order");
    // Foreign rd write ignored, load and store keep their access
    r = base_rec(32'h100, {7'h0, 5'd2, 5'd1, 3'b000, 5'd5, opc_op});
    step();
    issue(r);
    step();
    ex_valid <= 1'b1;
    step();
    wb_valid <= 1'b1;
    wb_write(5'd6, 32'hdead_beef);
    r = base_rec(32'h104, {12'h010, 5'd2, 3'b010, 5'd7, opc_load});
    r.rd_we    = 1'b1;
    r.rd_wdata = rnd(32);
    r.mem_addr = rnd(32);
    r.mem_cnt  = 2'd1;
    step();
    issue(r);
    step();
    ex_valid <= 1'b1;
    grant(1'b0, r.mem_addr, 32'h0);
    step();
    wb_valid <= 1'b1;
    wb_write(5'd7, r.rd_wdata);
    r = base_rec(32'h108, {7'h0, 5'd3, 5'd2, 3'b010, 5'd4, opc_store});
    {r.mem_we, r.mem_addr, r.mem_wdata, r.mem_cnt} = {1'b1, rnd(32), rnd(32), 2'd1};
    step();
    issue(r);
    step();
    ex_valid <= 1'b1;
    grant(1'b1, r.mem_addr, r.mem_wdata);
    step();
    wb_valid <= 1'b1;
    drain();
    end_test("rd_and_mem");
    // Misaligned access stays in EX, then a bypass retiring before an older instruction
    r = base_rec(32'h200, {12'h013, 5'd2, 3'b010, 5'd9, opc_load});
    {r.rd_we, r.rd_wdata, r.mem_addr, r.mem_cnt} = {1'b1, rnd(32), 32'h1013, 2'd2};
    a1 = r.mem_addr + 32'h4;
    step();
    issue(r);
    step();
    ex_valid <= 1'b1;
    data_misaligned <= 1'b1;
    grant(1'b0, r.mem_addr, 32'h0);
    step();
    ex_valid <= 1'b1;
    grant(1'b0, a1, 32'h0);
    wb_write(5'd9, r.rd_wdata);
    step();
    wb_valid <= 1'b1;
    r = base_rec(32'h210, {12'h001, 5'd1, 3'b000, 5'd3, opc_op_imm});
    r2 = base_rec(32'h214, {12'h002, 5'd1, 3'b000, 5'd4, opc_op_imm});
    r2.bypass = 1'b1;
    step();
    issue(r);
    step();
    ex_valid <= 1'b1;
    issue(r2);
    step();
    wb_bypass <= 1'b1;
    step();
    wb_valid <= 1'b1;
    drain();
    end_test("misaligned_bypass");
    // MRET through WB-delay ahead of a younger instruction, then EBREAK into debug
    r = base_rec(32'h300, {funct12_mret, 5'd0, 3'b000, 5'd0, opc_system});
    r2 = base_rec(32'h304, {12'h005, 5'd1, 3'b000, 5'd8, opc_op_imm});
    {r2.rd_we, r2.rd_wdata} = {1'b1, rnd(32)};
    step();
    issue(r);
    step();
    ex_valid <= 1'b1;
    issue(r2);
    step();
    wb_valid <= 1'b1;
    ex_valid <= 1'b1;
    step();
    wb_valid <= 1'b1;
    wb_write(5'd8, r2.rd_wdata);
    // MRET leaves WB-delay one edge after WB, so its record shows a cycle later
    step();
    step();
    if (trace_valid) begin
      $display("MRET record came out without its WB-delay cycle");
      err_cnt++;
    end
    drain();
    r = base_rec(32'h400, {funct12_ebreak, 5'd0, 3'b000, 5'd0, opc_system});
    r.ebreak = 1'b1;
    step();
    issue(r);
    repeat (6) begin
      step();
      if (trace_valid) begin
        $display("EBREAK record came out before debug_mode was high");
        err_cnt++;
      end
    end
    debug_mode <= 1'b1;
    drain();
    debug_mode <= 1'b0;
    end_test("mret_ebreak");
    // Overflow behind a parked EBREAK, orphan WB write, then reset clears flags and records
    r = base_rec(32'h4fc, {funct12_ebreak, 5'd0, 3'b000, 5'd0, opc_system});
    r.ebreak = 1'b1;
    step();
    drive_decode(r);
    for (int i = 0; i < store_depth; i++) begin
      step();
      drive_decode(base_rec(32'h500 + 4 * i, {12'h0, 5'd0, 3'b000, 5'd1, opc_op_imm}));
    end
    step();
    step();
    check_field("trace_overflow", trace_overflow, 1'b1);
    check_field("trace_error", trace_error, 1'b0);
    step();
    wb_write(5'd1, 32'h1234);
    step();
    step();
    check_field("trace_error", trace_error, 1'b1);
    rst_n <= 1'b0;
    debug_mode <= 1'b1;
    repeat (3) step();
    check_field("trace_valid", trace_valid, 1'b0);
    check_field("trace_error", trace_error, 1'b0);
    check_field("trace_overflow", trace_overflow, 1'b0);
    has_last <= 1'b0;
    rst_n <= 1'b1;
    // The parked EBREAK is gone, so debug entry releases no record
    repeat (3) step();
    debug_mode <= 1'b0;
    step();
    end_test("flags_reset");
  endtask

`endif

//--- tb/tb_instr_trace_unit.sv
// Testbench for the retirement trace unit, a small core stand-in drives the DUT strobes
`timescale 1ns/1ps

module tb_instr_trace_unit;

  import core_isa_pkg::*;
  import trace_pkg::*;

  // Reset 5, test 1 about 80, tests 2 to 4 about 40 each, test 5 about 40, with margin
  localparam int max_cycles = 400;

  logic clk_i, rst_n;
  logic id_valid, is_decoding, is_illegal, trigger_match, ebrk_insn;
  logic ebrk_force_debug_mode, debug_mode, compressed;
  logic [xlen-1:0] pc, instr;
  logic ex_valid, data_misaligned, wb_bypass, ex_reg_we, ex_data_req, ex_data_gnt, ex_data_we;
  logic [reg_w-1:0] ex_reg_addr, wb_reg_addr;
  logic [xlen-1:0] ex_reg_wdata, ex_data_addr, ex_data_wdata, wb_reg_wdata;
  logic wb_valid, wb_reg_we;
  logic trace_valid, trace_compressed, trace_rd_we, trace_mem_valid, trace_mem_we;
  logic trace_ebreak, trace_bypass, trace_error, trace_overflow;
  logic [xlen-1:0] trace_pc, trace_instr, trace_rd_wdata, trace_mem_addr, trace_mem_wdata;
  logic [reg_w-1:0] trace_rd_addr;
  logic [mem_cnt_w-1:0] trace_mem_cnt;
  logic [cycle_w-1:0] trace_cycle, last_cycle, cyc;
  logic has_last;

  logic [31:0] lfsr;
  int          err_cnt, test_base, pass_cnt, fail_cnt, wd_cnt;
  trace_rec_t  exp_q[$];

  instr_trace_unit u_dut (.*);

  always #20 clk_i = ~clk_i;

  // Mirror of the issue cycle count, restarted by reset
  always @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 1'b1;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rnd(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
      err_cnt++;
    end
  endtask

  // ------------------------------------------------
  // Trace monitor
  // ------------------------------------------------
  always @(posedge clk_i) begin
    trace_rec_t e;
    if (rst_n && trace_valid) begin
      if (exp_q.size() == 0) begin
        $display("Trace record seen with no instruction outstanding, pc 0x%h", trace_pc);
        err_cnt++;
      end else begin
        e = exp_q.pop_front();
        check_field("trace_pc", trace_pc, e.pc);
        check_field("trace_instr", trace_instr, e.instr);
        check_field("trace_compressed", trace_compressed, e.compressed);
        check_field("trace_rd_we", trace_rd_we, e.rd_we);
        check_field("trace_rd_addr", trace_rd_addr, e.rd_addr);
        if (e.rd_we) check_field("trace_rd_wdata", trace_rd_wdata, e.rd_wdata);
        check_field("trace_mem_valid", trace_mem_valid, e.mem_cnt != 0);
        check_field("trace_mem_cnt", trace_mem_cnt, e.mem_cnt);
        if (e.mem_cnt != 0) begin
          check_field("trace_mem_we", trace_mem_we, e.mem_we);
          check_field("trace_mem_addr", trace_mem_addr, e.mem_addr);
          check_field("trace_mem_wdata", trace_mem_wdata, e.mem_wdata);
        end
        check_field("trace_ebreak", trace_ebreak, e.ebreak);
        check_field("trace_bypass", trace_bypass, e.bypass);
        check_field("trace_cycle", trace_cycle, e.cycle);
        if (has_last && trace_cycle <= last_cycle) begin
          $display("Issue cycle did not rise from one record to the next");
          err_cnt++;
        end
      end
      has_last   <= 1'b1;
      last_cycle <= trace_cycle;
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    wd_cnt++;
    if (wd_cnt >= max_cycles) begin
      $display("Run stopped after %0d cycles with records still outstanding", wd_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  `include "trace_tests.svh"

  initial begin
    clk_i = 1'b0;
    rst_n = 1'b0;
    lfsr  = 32'h208e;
    {id_valid, is_decoding, is_illegal, trigger_match, ebrk_insn} = '0;
    {ebrk_force_debug_mode, debug_mode, compressed, pc, instr} = '0;
    {ex_valid, data_misaligned, wb_bypass, ex_reg_we, ex_reg_addr, ex_reg_wdata} = '0;
    {ex_data_req, ex_data_gnt, ex_data_we, ex_data_addr, ex_data_wdata} = '0;
    {wb_valid, wb_reg_we, wb_reg_addr, wb_reg_wdata} = '0;
    {err_cnt, pass_cnt, fail_cnt, wd_cnt, has_last, last_cycle} = '0;
    repeat (5) @(posedge clk_i);
    rst_n <= 1'b1;
    run_all_tests();
    $display("Tests passed %0d, failed %0d, failed checks %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- source/instr_trace_unit.sv
// Retirement trace unit top, connecting the stage tracker to the in-order record store
`timescale 1ns/1ps

module instr_trace_unit (
  input  logic                            clk_i,
  input  logic                            rst_n,
  input  logic                            id_valid,
  input  logic                            is_decoding,
  input  logic                            is_illegal,
  input  logic                            trigger_match,
  input  logic                            ebrk_insn,
  input  logic                            ebrk_force_debug_mode,
  input  logic                            debug_mode,
  input  logic [core_isa_pkg::xlen-1:0]   pc,
  input  logic [core_isa_pkg::xlen-1:0]   instr,
  input  logic                            compressed,
  input  logic                            ex_valid,
  input  logic                            data_misaligned,
  input  logic                            wb_bypass,
  input  logic                            ex_reg_we,
  input  logic [core_isa_pkg::reg_w-1:0]  ex_reg_addr,
  input  logic [core_isa_pkg::xlen-1:0]   ex_reg_wdata,
  input  logic                            ex_data_req,
  input  logic                            ex_data_gnt,
  input  logic                            ex_data_we,
  input  logic [core_isa_pkg::xlen-1:0]   ex_data_addr,
  input  logic [core_isa_pkg::xlen-1:0]   ex_data_wdata,
  input  logic                            wb_valid,
  input  logic                            wb_reg_we,
  input  logic [core_isa_pkg::reg_w-1:0]  wb_reg_addr,
  input  logic [core_isa_pkg::xlen-1:0]   wb_reg_wdata,
  output logic                            trace_valid,
  output logic [core_isa_pkg::xlen-1:0]   trace_pc,
  output logic [core_isa_pkg::xlen-1:0]   trace_instr,
  output logic                            trace_compressed,
  output logic                            trace_rd_we,
  output logic [core_isa_pkg::reg_w-1:0]  trace_rd_addr,
  output logic [core_isa_pkg::xlen-1:0]   trace_rd_wdata,
  output logic                            trace_mem_valid,
  output logic                            trace_mem_we,
  output logic [core_isa_pkg::xlen-1:0]   trace_mem_addr,
  output logic [core_isa_pkg::xlen-1:0]   trace_mem_wdata,
  output logic [trace_pkg::mem_cnt_w-1:0] trace_mem_cnt,
  output logic                            trace_ebreak,
  output logic                            trace_bypass,
  output logic [trace_pkg::cycle_w-1:0]   trace_cycle,
  output logic                            trace_error,
  output logic                            trace_overflow
);

  import core_isa_pkg::*;
  import trace_pkg::*;

  logic             alloc_valid, alloc_ebreak, store_full;
  logic [tag_w-1:0] alloc_tag, rd_tag, mem_tag, ex_retire_tag, wb_retire_tag, dly_retire_tag;
  logic             rd_ex_we, rd_wb_we, mem_valid, mem_we;
  logic             ex_retire, ex_bypass, wb_retire, dly_retire;
  logic [reg_w-1:0] rd_addr;
  logic [xlen-1:0]  rd_wdata, mem_addr, mem_wdata;

  trace_stage_track u_track (
    .clk_i, .rst_n, .id_valid, .is_decoding, .is_illegal, .trigger_match, .ebrk_insn,
    .ebrk_force_debug_mode, .debug_mode, .instr, .ex_valid, .data_misaligned, .wb_bypass,
    .ex_reg_we, .ex_reg_addr, .ex_reg_wdata, .ex_data_req, .ex_data_gnt, .ex_data_we,
    .ex_data_addr, .ex_data_wdata, .wb_valid, .wb_reg_we, .wb_reg_addr, .wb_reg_wdata,
    .alloc_tag, .store_full, .alloc_valid, .alloc_ebreak, .rd_ex_we, .rd_wb_we, .rd_tag,
    .rd_addr, .rd_wdata, .mem_valid, .mem_tag, .mem_we, .mem_addr, .mem_wdata,
    .ex_retire, .ex_retire_tag, .ex_bypass, .wb_retire, .wb_retire_tag,
    .dly_retire, .dly_retire_tag, .trace_error
  );

  trace_record_store u_store (
    .clk_i, .rst_n, .pc, .instr, .compressed, .debug_mode, .alloc_valid, .alloc_ebreak,
    .rd_ex_we, .rd_wb_we, .rd_tag, .rd_addr, .rd_wdata, .mem_valid, .mem_tag, .mem_we,
    .mem_addr, .mem_wdata, .ex_retire, .ex_retire_tag, .ex_bypass, .wb_retire,
    .wb_retire_tag, .dly_retire, .dly_retire_tag, .alloc_tag, .store_full,
    .trace_valid, .trace_pc, .trace_instr, .trace_compressed, .trace_rd_we, .trace_rd_addr,
    .trace_rd_wdata, .trace_mem_valid, .trace_mem_we, .trace_mem_addr, .trace_mem_wdata,
    .trace_mem_cnt, .trace_ebreak, .trace_bypass, .trace_cycle, .trace_overflow
  );

endmodule

//--- source/trace_record_store.sv
// Circular store of trace records, updated by tag and emitted in issue order once retired
`timescale 1ns/1ps

module trace_record_store (
  input  logic                               clk_i,
  input  logic                               rst_n,
  input  logic [core_isa_pkg::xlen-1:0]      pc,
  input  logic [core_isa_pkg::xlen-1:0]      instr,
  input  logic                               compressed,
  input  logic                               debug_mode,
  // Events from the tracker
  input  logic                               alloc_valid,
  input  logic                               alloc_ebreak,
  input  logic                               rd_ex_we,
  input  logic                               rd_wb_we,
  input  logic [trace_pkg::tag_w-1:0]        rd_tag,
  input  logic [core_isa_pkg::reg_w-1:0]     rd_addr,
  input  logic [core_isa_pkg::xlen-1:0]      rd_wdata,
  input  logic                               mem_valid,
  input  logic [trace_pkg::tag_w-1:0]        mem_tag,
  input  logic                               mem_we,
  input  logic [core_isa_pkg::xlen-1:0]      mem_addr,
  input  logic [core_isa_pkg::xlen-1:0]      mem_wdata,
  input  logic                               ex_retire,
  input  logic [trace_pkg::tag_w-1:0]        ex_retire_tag,
  input  logic                               ex_bypass,
  input  logic                               wb_retire,
  input  logic [trace_pkg::tag_w-1:0]        wb_retire_tag,
  input  logic                               dly_retire,
  input  logic [trace_pkg::tag_w-1:0]        dly_retire_tag,
  output logic [trace_pkg::tag_w-1:0]        alloc_tag,
  output logic                               store_full,
  // Trace output
  output logic                               trace_valid,
  output logic [core_isa_pkg::xlen-1:0]      trace_pc,
  output logic [core_isa_pkg::xlen-1:0]      trace_instr,
  output logic                               trace_compressed,
  output logic                               trace_rd_we,
  output logic [core_isa_pkg::reg_w-1:0]     trace_rd_addr,
  output logic [core_isa_pkg::xlen-1:0]      trace_rd_wdata,
  output logic                               trace_mem_valid,
  output logic                               trace_mem_we,
  output logic [core_isa_pkg::xlen-1:0]      trace_mem_addr,
  output logic [core_isa_pkg::xlen-1:0]      trace_mem_wdata,
  output logic [trace_pkg::mem_cnt_w-1:0]    trace_mem_cnt,
  output logic                               trace_ebreak,
  output logic                               trace_bypass,
  output logic [trace_pkg::cycle_w-1:0]      trace_cycle,
  output logic                               trace_overflow
);

  import core_isa_pkg::*;
  import trace_pkg::*;

  rec_state_e         state_q [store_depth];
  trace_rec_t         rec_q [store_depth];
  trace_rec_t         out_q;
  logic [tag_w-1:0]   head_q, tail_q;
  logic [tag_w:0]     count_q;
  logic [cycle_w-1:0] cycle_q;
  logic               valid_q, overflow_q, alloc_req, alloc_ok, pop;

  assign alloc_req  = alloc_valid || alloc_ebreak;
  assign store_full = (count_q == (tag_w+1)'(store_depth));
  assign alloc_ok   = alloc_req && !store_full;
  assign alloc_tag  = tail_q;
  // Head leaves once retired, an EBREAK only after debug entry
  assign pop = (state_q[head_q] == rec_retired) && (!rec_q[head_q].ebreak || debug_mode);

  // --------------------------------------------------
  // Record states and pointers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < store_depth; i++) begin
        state_q[i] <= rec_free;
      end
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      cycle_q    <= '0;
      valid_q    <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      valid_q <= pop;
      if (alloc_req && store_full) begin
        overflow_q <= 1'b1;
      end
      if (alloc_ok) begin
        state_q[tail_q] <= alloc_ebreak ? rec_retired : rec_open;
        tail_q          <= tail_q + 1'b1;
      end
      if (ex_retire) state_q[ex_retire_tag] <= rec_retired;
      if (wb_retire) state_q[wb_retire_tag] <= rec_retired;
      if (dly_retire) state_q[dly_retire_tag] <= rec_retired;
      if (pop) begin
        state_q[head_q] <= rec_free;
        head_q          <= head_q + 1'b1;
      end
      count_q <= count_q + (tag_w+1)'(alloc_ok) - (tag_w+1)'(pop);
    end
  end

  // --------------------------------------------------
  // Record payload and output register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_ok) begin
      rec_q[tail_q]         <= '0;
      rec_q[tail_q].pc      <= pc;
      rec_q[tail_q].instr   <= instr;
      rec_q[tail_q].rd_addr <= instr[rd_msb:rd_lsb];
      rec_q[tail_q].ebreak  <= alloc_ebreak;
      rec_q[tail_q].cycle   <= cycle_q;
      rec_q[tail_q].compressed <= compressed;
    end
    // Writes to any other register than rd are dropped
    if ((rd_ex_we || rd_wb_we) && (rd_addr == rec_q[rd_tag].rd_addr)) begin
      rec_q[rd_tag].rd_we    <= 1'b1;
      rec_q[rd_tag].rd_wdata <= rd_wdata;
    end
    if (mem_valid) begin
      if (rec_q[mem_tag].mem_cnt == '0) begin
        rec_q[mem_tag].mem_we    <= mem_we;
        rec_q[mem_tag].mem_addr  <= mem_addr;
        rec_q[mem_tag].mem_wdata <= mem_wdata;
      end
      if (rec_q[mem_tag].mem_cnt != '1) begin
        rec_q[mem_tag].mem_cnt <= rec_q[mem_tag].mem_cnt + 1'b1;
      end
    end
    if (ex_retire && ex_bypass) begin
      rec_q[ex_retire_tag].bypass <= 1'b1;
    end
    if (pop) begin
      out_q <= rec_q[head_q];
    end
  end

  assign trace_valid      = valid_q;
  assign trace_pc         = out_q.pc;
  assign trace_instr      = out_q.instr;
  assign trace_compressed = out_q.compressed;
  assign trace_rd_we      = out_q.rd_we;
  assign trace_rd_addr    = out_q.rd_addr;
  assign trace_rd_wdata   = out_q.rd_wdata;
  assign trace_mem_valid  = (out_q.mem_cnt != '0);
  assign trace_mem_we     = out_q.mem_we;
  assign trace_mem_addr   = out_q.mem_addr;
  assign trace_mem_wdata  = out_q.mem_wdata;
  assign trace_mem_cnt    = out_q.mem_cnt;
  assign trace_ebreak     = out_q.ebreak;
  assign trace_bypass     = out_q.bypass;
  assign trace_cycle      = out_q.cycle;
  assign trace_overflow   = overflow_q;

endmodule

//--- source/trace_stage_track.sv
// Follows tagged instructions through EX, WB and WB-delay and turns core strobes into store events
`timescale 1ns/1ps

module trace_stage_track (
  input  logic                           clk_i,
  input  logic                           rst_n,
  // Decode
  input  logic                           id_valid,
  input  logic                           is_decoding,
  input  logic                           is_illegal,
  input  logic                           trigger_match,
  input  logic                           ebrk_insn,
  input  logic                           ebrk_force_debug_mode,
  input  logic                           debug_mode,
  input  logic [core_isa_pkg::xlen-1:0]  instr,
  // Execute
  input  logic                           ex_valid,
  input  logic                           data_misaligned,
  input  logic                           wb_bypass,
  input  logic                           ex_reg_we,
  input  logic [core_isa_pkg::reg_w-1:0] ex_reg_addr,
  input  logic [core_isa_pkg::xlen-1:0]  ex_reg_wdata,
  input  logic                           ex_data_req,
  input  logic                           ex_data_gnt,
  input  logic                           ex_data_we,
  input  logic [core_isa_pkg::xlen-1:0]  ex_data_addr,
  input  logic [core_isa_pkg::xlen-1:0]  ex_data_wdata,
  // Writeback
  input  logic                           wb_valid,
  input  logic                           wb_reg_we,
  input  logic [core_isa_pkg::reg_w-1:0] wb_reg_addr,
  input  logic [core_isa_pkg::xlen-1:0]  wb_reg_wdata,
  // Store feedback
  input  logic [trace_pkg::tag_w-1:0]    alloc_tag,
  input  logic                           store_full,
  // Store events
  output logic                           alloc_valid,
  output logic                           alloc_ebreak,
  output logic                           rd_ex_we,
  output logic                           rd_wb_we,
  output logic [trace_pkg::tag_w-1:0]    rd_tag,
  output logic [core_isa_pkg::reg_w-1:0] rd_addr,
  output logic [core_isa_pkg::xlen-1:0]  rd_wdata,
  output logic                           mem_valid,
  output logic [trace_pkg::tag_w-1:0]    mem_tag,
  output logic                           mem_we,
  output logic [core_isa_pkg::xlen-1:0]  mem_addr,
  output logic [core_isa_pkg::xlen-1:0]  mem_wdata,
  output logic                           ex_retire,
  output logic [trace_pkg::tag_w-1:0]    ex_retire_tag,
  output logic                           ex_bypass,
  output logic                           wb_retire,
  output logic [trace_pkg::tag_w-1:0]    wb_retire_tag,
  output logic                           dly_retire,
  output logic [trace_pkg::tag_w-1:0]    dly_retire_tag,
  output logic                           trace_error
);

  import core_isa_pkg::*;
  import trace_pkg::*;

  stage_state_e     ex_state_q, wb_state_q, dly_state_q;
  logic [tag_w-1:0] ex_tag_q, wb_tag_q, dly_tag_q;
  logic             ex_dly_q, wb_dly_q;
  logic             instr_is_dly, alloc_ok, ex_busy, wb_busy;
  logic             ex_stall, ex_to_wb, wb_to_dly, ex_err, wb_err, error_q;

  // --------------------------------------------------
  // Decode and stage movement
  // --------------------------------------------------
  assign instr_is_dly = (instr[6:0] == opc_system) &&
                        ((instr[funct12_msb:funct12_lsb] == funct12_mret) ||
                         (instr[funct12_msb:funct12_lsb] == funct12_uret) ||
                         (instr[funct12_msb:funct12_lsb] == funct12_ebreak));

  assign alloc_valid  = id_valid && is_decoding && !is_illegal;
  // EBREAK into debug skips the pipeline entirely
  assign alloc_ebreak = !alloc_valid && is_decoding && !trigger_match && ebrk_insn &&
                        (ebrk_force_debug_mode || debug_mode);
  assign alloc_ok     = alloc_valid && !store_full;

  assign ex_busy  = (ex_state_q != stg_empty);
  assign wb_busy  = (wb_state_q != stg_empty);
  assign ex_stall = ex_busy && ex_valid && data_misaligned;
  assign ex_to_wb = ex_busy && !ex_stall && !wb_bypass && ex_valid;

  assign ex_retire      = ex_busy && !ex_stall && wb_bypass;
  assign ex_retire_tag  = ex_tag_q;
  assign ex_bypass      = ex_retire;
  assign wb_to_dly      = wb_busy && wb_valid && wb_dly_q;
  assign wb_retire      = wb_busy && wb_valid && !wb_dly_q;
  assign wb_retire_tag  = wb_tag_q;
  assign dly_retire     = (dly_state_q != stg_empty);
  assign dly_retire_tag = dly_tag_q;

  // --------------------------------------------------
  // Register and memory event mapping
  // --------------------------------------------------
  // A WB write lands on the misaligned EX entry when WB is empty
  assign rd_wb_we = wb_reg_we && (wb_busy || (ex_state_q == stg_misaligned));
  assign rd_ex_we = ex_reg_we && ex_busy && !rd_wb_we;
  assign rd_tag   = (rd_wb_we && wb_busy) ? wb_tag_q : ex_tag_q;
  assign rd_addr  = rd_wb_we ? wb_reg_addr : ex_reg_addr;
  assign rd_wdata = rd_wb_we ? wb_reg_wdata : ex_reg_wdata;

  assign mem_valid = ex_data_req && ex_data_gnt && ex_busy;
  assign mem_tag   = ex_tag_q;
  assign mem_we    = ex_data_we;
  assign mem_addr  = ex_data_addr;
  assign mem_wdata = ex_data_wdata;

  assign ex_err      = !ex_busy && (ex_reg_we || (ex_data_req && ex_data_gnt));
  assign wb_err      = wb_reg_we && !rd_wb_we;
  assign trace_error = error_q;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_state_q  <= stg_empty;
      wb_state_q  <= stg_empty;
      dly_state_q <= stg_empty;
      error_q     <= 1'b0;
    end else begin
      if (ex_err || wb_err) begin
        error_q <= 1'b1;
      end
      if (alloc_ok) begin
        ex_state_q <= stg_busy;
      end else if (ex_stall) begin
        ex_state_q <= stg_misaligned;
      end else if (ex_retire || ex_to_wb) begin
        ex_state_q <= stg_empty;
      end
      if (ex_to_wb) begin
        wb_state_q <= stg_busy;
      end else if (wb_to_dly || wb_retire) begin
        wb_state_q <= stg_empty;
      end
      // WB-delay holds an entry for exactly one cycle
      dly_state_q <= wb_to_dly ? stg_busy : stg_empty;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_ok) begin
      ex_tag_q <= alloc_tag;
      ex_dly_q <= instr_is_dly;
    end
    if (ex_to_wb) begin
      wb_tag_q <= ex_tag_q;
      wb_dly_q <= ex_dly_q;
    end
    if (wb_to_dly) begin
      dly_tag_q <= wb_tag_q;
    end
  end

endmodule

//--- source/trace_pkg.sv
// Trace record layout, tag sizing and state encodings shared by the tracker and the store
package trace_pkg;

  // Record store sizing
  localparam int store_depth = 8;
  localparam int tag_w       = $clog2(store_depth);

  // Saturating count of granted accesses and issue cycle stamp
  localparam int mem_cnt_w = 2;
  localparam int cycle_w   = 32;

  // Occupancy of a pipeline stage entry
  typedef enum logic [1:0] {
    stg_empty,
    stg_busy,
    stg_misaligned
  } stage_state_e;

  // Lifetime of a record in the store
  typedef enum logic [1:0] {
    rec_free,
    rec_open,
    rec_retired
  } rec_state_e;

  // Payload of one retired instruction
  typedef struct packed {
    logic [core_isa_pkg::xlen-1:0]  pc;
    logic [core_isa_pkg::xlen-1:0]  instr;
    logic                           compressed;
    logic                           rd_we;
    logic [core_isa_pkg::reg_w-1:0] rd_addr;
    logic [core_isa_pkg::xlen-1:0]  rd_wdata;
    logic                           mem_we;
    logic [core_isa_pkg::xlen-1:0]  mem_addr;
    logic [core_isa_pkg::xlen-1:0]  mem_wdata;
    logic [mem_cnt_w-1:0]           mem_cnt;
    logic                           ebreak;
    logic                           bypass;
    logic [cycle_w-1:0]             cycle;
  } trace_rec_t;

endpackage

//--- source/core_isa_pkg.sv
// RISC-V opcodes and instruction fields used to classify decoded instructions for tracing
package core_isa_pkg;

  // Data and address width
  localparam int xlen = 32;

  // Major opcodes seen by the tracker and the core stand-in
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  // Destination register field
  localparam int rd_lsb = 7;
  localparam int rd_msb = 11;
  localparam int reg_w  = rd_msb - rd_lsb + 1;

  // Immediate field of SYSTEM instructions
  localparam int funct12_lsb = 20;
  localparam int funct12_msb = 31;

  // System instructions that retire through WB-delay
  localparam logic [11:0] funct12_mret   = 12'h302;
  localparam logic [11:0] funct12_uret   = 12'h002;
  localparam logic [11:0] funct12_ebreak = 12'h001;

endpackage
